//--- if_stage.f
source/if_stage_pkg.sv
source/if_pc_select.sv
source/if_fetch_fifo.sv
source/if_prefetch_buffer.sv
source/if_stage.sv
verification/if_imem_model.sv
verification/if_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the fetch stage testbench with Verilator and run it
# exit status is nonzero when the simulation ends in $fatal
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f if_stage.f --top-module if_stage_tb -o if_stage_sim &&
./obj_dir/if_stage_sim ||
exit 1

//--- source/if_fetch_fifo.sv
/* Circular FIFO of fetch entries, FIFO_DEPTH deep. Flush beats push and pop
   in the same cycle; pushing when full or popping when empty is illegal */
`timescale 1ns/10ps

module if_fetch_fifo (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                flush_i,
  input  logic                                push_i,
  input  if_stage_pkg::fetch_entry_t          data_i,
  output logic                                full_o,
  input  logic                                pop_i,
  output if_stage_pkg::fetch_entry_t          data_o,
  output logic                                empty_o,
  output logic [if_stage_pkg::FIFO_CNT_W-1:0] count_o
);

  import if_stage_pkg::*;

  fetch_entry_t          mem_q [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr_q;
  logic [FIFO_PTR_W-1:0] rd_ptr_q;
  logic [FIFO_CNT_W-1:0] count_q;
  logic                  push_en;
  logic                  pop_en;

  assign full_o  = (count_q == FIFO_CNT_W'(FIFO_DEPTH));
  assign empty_o = (count_q == '0);
  assign count_o = count_q;
  assign data_o  = mem_q[rd_ptr_q];

  // a flush kills whatever else happens this cycle
  assign push_en = push_i & ~full_o & ~flush_i;
  assign pop_en  = pop_i & ~empty_o & ~flush_i;

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_en) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      if (push_en && !pop_en) begin
        count_q <= count_q + 1'b1;
      end else if (pop_en && !push_en) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (push_en) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // producer must respect full, consumer must respect empty
  assert property (@(posedge clk) disable iff (!rst_n) push_i |-> !full_o)
    else $error("fetch fifo pushed while full");
  assert property (@(posedge clk) disable iff (!rst_n) pop_i |-> !empty_o)
    else $error("fetch fifo popped while empty");

endmodule

//--- source/if_pc_select.sv
/* Purely combinational next-PC mux, no latency. Every result is forced to
   a word boundary since compressed instructions are not supported */
`timescale 1ns/10ps

module if_pc_select (
  input  logic [if_stage_pkg::TRAP_BASE_W-1:0] trap_base_i,
  input  logic [31:0]                          boot_addr_i,
  input  if_stage_pkg::redirect_t              redirect_i,
  output logic [31:0]                          fetch_addr_o
);

  import if_stage_pkg::*;

  logic [31:0] exc_addr;
  logic [31:0] sel_addr;

  // ------------------------------------------------------------------
  // trap vector build
  // ------------------------------------------------------------------

  always_comb begin
    unique case (redirect_i.exc_src)
      // vectored mode, one 4-byte slot per interrupt line
      // bit 7 is kept zero so irq slots sit in the lower half
      EXC_IRQ: begin
        exc_addr = {trap_base_i, 1'b0, redirect_i.irq_id, 2'b00};
      end
      // all sync exceptions land on the trap base itself
      default: begin
        exc_addr = {trap_base_i, 8'h00};
      end
    endcase
  end

  // ------------------------------------------------------------------
  // next fetch address
  // ------------------------------------------------------------------

  always_comb begin
    unique case (redirect_i.pc_src)
      PC_BOOT: begin
        sel_addr = boot_addr_i;
      end
      // jump target resolved in decode
      PC_JUMP: begin
        sel_addr = redirect_i.target;
      end
      // taken branch resolved in execute
      PC_BRANCH: begin
        sel_addr = redirect_i.target;
      end
      PC_EXCEPTION: begin
        sel_addr = exc_addr;
      end
      // return to the saved exception pc
      PC_MRET: begin
        sel_addr = redirect_i.target;
      end
      // refetch the word after the fence.i, flushing stale prefetches
      PC_FENCEI: begin
        sel_addr = redirect_i.target + 32'd4;
      end
      default: begin
        sel_addr = boot_addr_i;
      end
    endcase
  end

  // drop the low two bits, fetches are always whole words
  assign fetch_addr_o = {sel_addr[31:2], 2'b00};

endmodule

//--- source/if_prefetch_buffer.sv
/* Sequential word prefetcher on a req/gnt/rvalid bus with in-order responses.
   Requests stop while FIFO entries plus requests in flight reach FIFO_DEPTH */
`timescale 1ns/10ps

module if_prefetch_buffer (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       req_i,
  input  logic                       branch_i,
  input  logic [31:0]                addr_i,
  // instruction memory bus
  output logic                       instr_req_o,
  output logic [31:0]                instr_addr_o,
  input  logic                       instr_gnt_i,
  input  logic                       instr_rvalid_i,
  input  logic [31:0]                instr_rdata_i,
  input  logic                       instr_err_i,
  // towards the IF/ID register
  output if_stage_pkg::fetch_entry_t entry_o,
  output logic                       valid_o,
  input  logic                       ready_i,
  output logic                       busy_o
);

  import if_stage_pkg::*;

  logic [31:0]           addr_q;
  logic [OUT_CNT_W-1:0]  outstanding_q;
  logic [OUT_CNT_W-1:0]  outstanding_d;
  logic [OUT_CNT_W-1:0]  discard_q;
  logic [OUT_CNT_W-1:0]  discard_d;
  logic [FIFO_CNT_W-1:0] fifo_count;
  logic [FIFO_CNT_W:0]   credit_used;
  logic                  fifo_full;
  logic                  fifo_empty;
  logic                  gnt_ok;
  logic                  rsp_drop;
  logic                  rsp_push;
  fetch_entry_t          rsp_entry;

  // ------------------------------------------------------------------
  // request side
  // ------------------------------------------------------------------

  // every granted word has a reserved FIFO slot, so a response never meets a full FIFO
  assign credit_used = (FIFO_CNT_W + 1)'(fifo_count) + (FIFO_CNT_W + 1)'(outstanding_q);

  // request is held low in the redirect cycle, the new address goes out next cycle
  assign instr_req_o = req_i & ~branch_i
                     & (credit_used < (FIFO_CNT_W + 1)'(FIFO_DEPTH))
                     & (outstanding_q < OUT_CNT_W'(MAX_OUTSTANDING));
  assign instr_addr_o = addr_q;
  assign gnt_ok       = instr_req_o & instr_gnt_i;

  // address only moves on a grant, so it stays put while waiting
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else if (branch_i) begin
      addr_q <= addr_i;
    end else if (gnt_ok) begin
      addr_q <= addr_q + 32'd4;
    end
  end

  // ------------------------------------------------------------------
  // outstanding and discard bookkeeping
  // ------------------------------------------------------------------

  always_comb begin
    outstanding_d = outstanding_q;
    if (gnt_ok && !instr_rvalid_i) begin
      outstanding_d = outstanding_q + 1'b1;
    end else if (!gnt_ok && instr_rvalid_i) begin
      outstanding_d = outstanding_q - 1'b1;
    end
  end

  // on a redirect all requests still in flight belong to the old stream;
  // a response arriving in the redirect cycle itself is dropped directly
  always_comb begin
    discard_d = discard_q;
    if (branch_i) begin
      discard_d = instr_rvalid_i ? outstanding_q - 1'b1 : outstanding_q;
    end else if (instr_rvalid_i && (discard_q != '0)) begin
      discard_d = discard_q - 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding_q <= '0;
      discard_q     <= '0;
    end else begin
      outstanding_q <= outstanding_d;
      discard_q     <= discard_d;
    end
  end

  // ------------------------------------------------------------------
  // response side
  // ------------------------------------------------------------------

  assign rsp_drop        = instr_rvalid_i & (branch_i | (discard_q != '0));
  assign rsp_push        = instr_rvalid_i & ~rsp_drop;
  assign rsp_entry.instr = instr_rdata_i;
  assign rsp_entry.err   = instr_err_i;

  if_fetch_fifo fifo0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (branch_i),
    .push_i  (rsp_push),
    .data_i  (rsp_entry),
    .full_o  (fifo_full),
    .pop_i   (ready_i),
    .data_o  (entry_o),
    .empty_o (fifo_empty),
    .count_o (fifo_count)
  );

  assign valid_o = ~fifo_empty;
  assign busy_o  = (outstanding_q != '0);

  // memory must not grant an idle bus nor answer with nothing in flight
  assert property (@(posedge clk) disable iff (!rst_n) instr_gnt_i |-> instr_req_o)
    else $error("grant without request");
  assert property (@(posedge clk) disable iff (!rst_n)
                   instr_rvalid_i |-> (outstanding_q != '0) && !(rsp_push && fifo_full))
    else $error("response with no request outstanding");

endmodule

//--- source/if_stage.sv
/* Fetch stage top: redirect FSM, next-PC mux, prefetcher and IF/ID register.
   Only aligned 32-bit fetches; the IF/ID slot empties once decode takes it */
`timescale 1ns/10ps

module if_stage (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic [31:0]                          boot_addr_i,
  input  logic [if_stage_pkg::TRAP_BASE_W-1:0] trap_base_i,
  // redirect from decode/execute/controller
  input  logic                                 pc_set_i,
  input  if_stage_pkg::redirect_t              redirect_i,
  // control
  input  logic                                 req_i,
  input  logic                                 halt_if_i,
  input  logic                                 id_ready_i,
  input  logic                                 clear_instr_valid_i,
  // instruction memory bus
  output logic                                 instr_req_o,
  output logic [31:0]                          instr_addr_o,
  input  logic                                 instr_gnt_i,
  input  logic                                 instr_rvalid_i,
  input  logic [31:0]                          instr_rdata_i,
  input  logic                                 instr_err_i,
  // IF/ID
  output logic                                 instr_valid_id_o,
  output if_stage_pkg::fetch_entry_t           if_id_o,
  output logic [31:0]                          branch_target_o,
  output logic                                 if_busy_o
);

  import if_stage_pkg::*;

  typedef enum logic {
    IDLE,
    RUN
  } fsm_e;

  fsm_e         state_q;
  fsm_e         state_d;
  redirect_t    sel_redirect;
  logic [31:0]  fetch_addr;
  logic         branch_req;
  logic         fetch_valid;
  logic         fetch_ready;
  logic         valid;
  fetch_entry_t fetch_entry;

  // ------------------------------------------------------------------
  // next pc
  // ------------------------------------------------------------------

  // without a redirect the mux points at the boot address
  always_comb begin
    sel_redirect = redirect_i;
    if (!pc_set_i) begin
      sel_redirect.pc_src = PC_BOOT;
    end
  end

  if_pc_select pc_sel0 (
    .trap_base_i  (trap_base_i),
    .boot_addr_i  (boot_addr_i),
    .redirect_i   (sel_redirect),
    .fetch_addr_o (fetch_addr)
  );

  assign branch_target_o = fetch_addr;

  // ------------------------------------------------------------------
  // redirect FSM
  // ------------------------------------------------------------------

  always_comb begin
    state_d    = state_q;
    branch_req = 1'b0;
    valid      = 1'b0;
    unique case (state_q)
      // nothing fetched yet, first req kicks off a boot fetch
      IDLE: begin
        if (req_i) begin
          branch_req = 1'b1;
          state_d    = RUN;
        end
      end
      RUN: begin
        valid = fetch_valid;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
    // redirect overrides everything, head of FIFO is stale now
    if (pc_set_i) begin
      branch_req = 1'b1;
      valid      = 1'b0;
      state_d    = RUN;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // pop only when decode can take a word this cycle
  assign fetch_ready = valid & id_ready_i & ~halt_if_i;

  if_prefetch_buffer pf0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i & (state_q == RUN)),
    .branch_i       (branch_req),
    .addr_i         (fetch_addr),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i),
    .entry_o        (fetch_entry),
    .valid_o        (fetch_valid),
    .ready_i        (fetch_ready),
    .busy_o         (if_busy_o)
  );

  // ------------------------------------------------------------------
  // IF/ID register
  // ------------------------------------------------------------------

  // valid drops when decode consumes the word and nothing new follows
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_valid_id_o <= 1'b0;
    end else if (fetch_ready) begin
      instr_valid_id_o <= 1'b1;
    end else if (clear_instr_valid_i || (id_ready_i && !halt_if_i)) begin
      instr_valid_id_o <= 1'b0;
    end
  end

  // payload frozen while stalled
  always_ff @(posedge clk) begin
    if (fetch_ready) begin
      if_id_o <= fetch_entry;
    end
  end

endmodule

//--- source/if_stage_pkg.sv
/* Shared types and sizes of the fetch stage. FIFO_DEPTH must be a power of two,
   and the trap base width assumes 8 low address bits below it */

package if_stage_pkg;

  // ------------------------------------------------------------------
  // sizing
  // ------------------------------------------------------------------

  // entries in the fetch FIFO
  localparam int FIFO_DEPTH      = 4;
  // requests in flight on the instruction bus
  localparam int MAX_OUTSTANDING = 2;
  // trap base is the upper part of the vector address
  localparam int TRAP_BASE_W     = 24;

  // derived widths
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam int OUT_CNT_W  = $clog2(MAX_OUTSTANDING + 1);

  // ------------------------------------------------------------------
  // types
  // ------------------------------------------------------------------

  // where the next fetch address comes from
  typedef enum logic [2:0] {
    PC_BOOT,
    PC_JUMP,
    PC_BRANCH,
    PC_EXCEPTION,
    PC_MRET,
    PC_FENCEI
  } pc_src_e;

  // sync exceptions share one vector, irqs are vectored by id
  typedef enum logic {
    EXC_SYNC,
    EXC_IRQ
  } exc_src_e;

  // redirect request from decode/execute/controller
  typedef struct packed {
    pc_src_e     pc_src;
    exc_src_e    exc_src;
    logic [4:0]  irq_id;
    logic [31:0] target;   // jump/branch target, mepc, or pc for fence.i
  } redirect_t;

  // one fetched word plus its bus error flag
  typedef struct packed {
    logic [31:0] instr;
    logic        err;
  } fetch_entry_t;

endpackage

//--- verification/if_imem_model.sv
/* Instruction memory model: word = address ^ 32'h13579bdf, err from 0x8000_0000 up.
   Responses in order, at least one cycle after the grant, no limit on requests in flight */
`timescale 1ns/10ps

module if_imem_model (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req_i,
  input  logic [31:0] addr_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o,
  output logic        err_o
);

  localparam logic [31:0] DATA_MASK = 32'h13579bdf;

  logic [31:0] lcg_q;
  logic        gnt_en_q;
  logic [1:0]  wait_q;
  logic [31:0] pending_q [$];

  // step of the shared linear congruential generator
  function automatic logic [31:0] rand_next();
    lcg_q = lcg_q * 32'd1664525 + 32'd1013904223;
    return lcg_q;
  endfunction

  // grant is combinational so it only ever answers a live request
  assign gnt_o = req_i & gnt_en_q;

  always @(posedge clk or negedge rst_n) begin
    logic [31:0] rnd;
    logic [31:0] head;
    if (!rst_n) begin
      lcg_q = 32'h4ed1;
      pending_q.delete();
      gnt_en_q <= 1'b0;
      wait_q   <= 2'd0;
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
      err_o    <= 1'b0;
    end else begin
      rnd      = rand_next();
      rvalid_o <= 1'b0;
      // oldest granted address answers once its wait runs out
      if (pending_q.size() != 0) begin
        if (wait_q == 2'd0) begin
          head = pending_q[0];
          pending_q.delete(0);
          rvalid_o <= 1'b1;
          rdata_o  <= head ^ DATA_MASK;
          err_o    <= head[31];
          wait_q   <= rnd[17:16];
        end else begin
          wait_q <= wait_q - 2'd1;
        end
      end
      // accepted request joins the back of the line
      if (req_i && gnt_o) begin
        pending_q.push_back(addr_i);
      end
      // grant about three cycles in four
      gnt_en_q <= (rnd[21:20] != 2'b00);
    end
  end

endmodule

//--- verification/if_stage_tb.sv
/* Testbench for the fetch stage. Expects the memory rule of if_imem_model and
   a clear pulse with every redirect, so the word in IF/ID is never taken twice */
`timescale 1ns/10ps

module if_stage_tb;

  import if_stage_pkg::*;

  localparam int CLK_HALF        = 10;
  localparam int CYCLES_PER_TEST = 400;

  logic                   clk;
  logic                   rst_n;
  logic [31:0]            boot_addr;
  logic [TRAP_BASE_W-1:0] trap_base;
  logic                   pc_set;
  redirect_t              redirect;
  logic                   req;
  logic                   halt_if;
  logic                   id_ready;
  logic                   clear_valid;
  logic                   instr_req;
  logic [31:0]            instr_addr;
  logic                   instr_gnt;
  logic                   instr_rvalid;
  logic [31:0]            instr_rdata;
  logic                   instr_err;
  logic                   instr_valid_id;
  fetch_entry_t           if_id;
  logic [31:0]            branch_target;
  logic                   if_busy;

  // reference stream state, owned by the compare process
  logic [31:0]  exp_addr     = '0;
  logic         booted       = 1'b0;
  int           accepted_cnt = 0;
  int           inflight     = 0;
  logic         prev_stall   = 1'b0;
  logic         prev_valid   = 1'b0;
  logic         prev_clear   = 1'b0;
  fetch_entry_t prev_entry   = '0;

  // owned by the stimulus process
  string        test_name    = "reset";
  int           test_idx     = 0;
  logic [31:0]  lcg_state    = 32'h4ed1;

  if_stage dut0 (
    .clk                 (clk),
    .rst_n               (rst_n),
    .boot_addr_i         (boot_addr),
    .trap_base_i         (trap_base),
    .pc_set_i            (pc_set),
    .redirect_i          (redirect),
    .req_i               (req),
    .halt_if_i           (halt_if),
    .id_ready_i          (id_ready),
    .clear_instr_valid_i (clear_valid),
    .instr_req_o         (instr_req),
    .instr_addr_o        (instr_addr),
    .instr_gnt_i         (instr_gnt),
    .instr_rvalid_i      (instr_rvalid),
    .instr_rdata_i       (instr_rdata),
    .instr_err_i         (instr_err),
    .instr_valid_id_o    (instr_valid_id),
    .if_id_o             (if_id),
    .branch_target_o     (branch_target),
    .if_busy_o           (if_busy)
  );

  if_imem_model imem0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_i    (instr_req),
    .addr_i   (instr_addr),
    .gnt_o    (instr_gnt),
    .rvalid_o (instr_rvalid),
    .rdata_o  (instr_rdata),
    .err_o    (instr_err)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // reference model and helpers
  // ----------------------------------------------------------------------

  // next fetch address as the fetch stage must pick it
  function automatic logic [31:0] ref_target(input logic set, input redirect_t r,
                                             input logic [31:0] boot,
                                             input logic [TRAP_BASE_W-1:0] base);
    logic [31:0] addr;
    logic [31:0] vec_base;
    vec_base = 32'(base) << 8;
    if (!set || r.pc_src == PC_BOOT) begin
      addr = boot;
    end else if (r.pc_src == PC_EXCEPTION) begin
      // irq slots are 4 bytes apart, bit 7 stays clear
      addr = (r.exc_src == EXC_IRQ) ? vec_base + (32'(r.irq_id) << 2) : vec_base;
    end else if (r.pc_src == PC_FENCEI) begin
      addr = r.target + 32'd4;
    end else begin
      addr = r.target;
    end
    return addr & ~32'd3;
  endfunction

  // word and error flag the memory returns for an address
  function automatic fetch_entry_t expected_entry(input logic [31:0] addr);
    fetch_entry_t e;
    e.instr = addr ^ 32'h13579bdf;
    e.err   = (addr >= 32'h8000_0000);
    return e;
  endfunction

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Verification failed");
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_idx  = test_idx + 1;
  endtask

  task automatic wait_accepted(input int n);
    int target;
    target = accepted_cnt + n;
    while (accepted_cnt < target) begin
      @(posedge clk);
    end
  endtask

  // one-cycle redirect, IF/ID word is killed in the same cycle
  task automatic apply_redirect(input pc_src_e src, input exc_src_e exc, input logic [4:0] irq,
                                input logic [31:0] target, input int n);
    redirect_t r;
    r.pc_src  = src;
    r.exc_src = exc;
    r.irq_id  = irq;
    r.target  = target;
    @(posedge clk);
    pc_set      <= 1'b1;
    redirect    <= r;
    clear_valid <= 1'b1;
    @(posedge clk);
    pc_set      <= 1'b0;
    clear_valid <= 1'b0;
    wait_accepted(n);
  endtask

  // ----------------------------------------------------------------------
  // compare process, samples mid-cycle when all signals are settled
  // ----------------------------------------------------------------------

  always @(negedge clk) begin
    logic        stall;
    logic [31:0] tgt;
    if (rst_n) begin
      stall = !(id_ready && !halt_if);
      // busy follows the words granted on the bus and not yet answered
      assert (if_busy == (inflight != 0)) else begin
        report_failure($sformatf("FAILED %s busy: expected %b, actual %b",
                                 test_name, inflight != 0, if_busy));
        $fatal(1);
      end
      inflight = inflight + int'(instr_req && instr_gnt) - int'(instr_rvalid);
      // a stalled IF/ID must keep its word
      if (prev_stall && prev_valid && !prev_clear) begin
        assert (instr_valid_id && if_id == prev_entry) else begin
          report_failure($sformatf("FAILED %s hold: expected %h, actual %h",
                                   test_name, prev_entry, if_id));
          $fatal(1);
        end
      end
      if (instr_valid_id && clear_valid) begin
        // killed word, skip it in the stream
        exp_addr = exp_addr + 32'd4;
      end else if (instr_valid_id && !stall) begin
        assert (if_id == expected_entry(exp_addr)) else begin
          report_failure($sformatf("FAILED %s: expected %h, actual %h",
                                   test_name, expected_entry(exp_addr), if_id));
          $fatal(1);
        end
        exp_addr     = exp_addr + 32'd4;
        accepted_cnt = accepted_cnt + 1;
      end
      // boot or redirect restarts the expected stream
      if (pc_set || (req && !booted)) begin
        tgt = ref_target(pc_set, redirect, boot_addr, trap_base);
        assert (branch_target == tgt) else begin
          report_failure($sformatf("FAILED %s target: expected %h, actual %h",
                                   test_name, tgt, branch_target));
          $fatal(1);
        end
        exp_addr = tgt;
        booted   = 1'b1;
      end
      prev_stall = stall;
      prev_valid = instr_valid_id;
      prev_clear = clear_valid;
      prev_entry = if_id;
    end
  end

  // each test gets its own cycle budget
  initial begin : watchdog
    int last_idx;
    int cycles;
    last_idx = 0;
    cycles   = 0;
    while (cycles <= CYCLES_PER_TEST) begin
      @(posedge clk);
      if (test_idx != last_idx) begin
        last_idx = test_idx;
        cycles   = 0;
      end else begin
        cycles = cycles + 1;
      end
    end
    report_failure($sformatf("timeout: test %s ran longer than %0d cycles",
                             test_name, CYCLES_PER_TEST));
    $fatal(1);
  end

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------

  initial begin
    logic [31:0] rnd;
    rst_n       = 1'b0;
    boot_addr   = 32'h0000_1000;
    trap_base   = 24'h000abc;
    pc_set      = 1'b0;
    redirect    = '0;
    req         = 1'b0;
    halt_if     = 1'b0;
    id_ready    = 1'b0;
    clear_valid = 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    start_test("boot");
    @(posedge clk);
    req      <= 1'b1;
    id_ready <= 1'b1;
    wait_accepted(8);

    // misaligned targets must come back word aligned
    start_test("jump");
    apply_redirect(PC_JUMP, EXC_SYNC, 5'd0, 32'h0000_2000, 6);
    start_test("branch");
    apply_redirect(PC_BRANCH, EXC_SYNC, 5'd0, 32'h0000_3006, 6);
    start_test("mret");
    apply_redirect(PC_MRET, EXC_SYNC, 5'd0, 32'h0000_4008, 6);
    start_test("fencei");
    apply_redirect(PC_FENCEI, EXC_SYNC, 5'd0, 32'h0000_2100, 6);

    start_test("exception");
    apply_redirect(PC_EXCEPTION, EXC_SYNC, 5'd9, 32'hdead_beef, 4);
    start_test("irq");
    apply_redirect(PC_EXCEPTION, EXC_IRQ, 5'd5, 32'h0, 4);
    apply_redirect(PC_EXCEPTION, EXC_IRQ, 5'd31, 32'h0, 4);

    // random stretches of decode stall and halt
    start_test("backpressure");
    apply_redirect(PC_JUMP, EXC_SYNC, 5'd0, 32'h0000_6000, 2);
    repeat (40) begin
      rnd = lcg_next();
      @(posedge clk);
      id_ready <= (rnd[3:2] != 2'b00);
      halt_if  <= (rnd[5:4] == 2'b00);
      repeat (rnd[9:8]) @(posedge clk);
    end
    @(posedge clk);
    id_ready <= 1'b1;
    halt_if  <= 1'b0;
    wait_accepted(6);

    start_test("fetch_error");
    apply_redirect(PC_JUMP, EXC_SYNC, 5'd0, 32'h8000_0000, 6);
    start_test("error_clear");
    apply_redirect(PC_JUMP, EXC_SYNC, 5'd0, 32'h0000_0100, 6);

    // stall until the FIFO holds words, let one into IF/ID, then stall again
    start_test("clear");
    @(posedge clk);
    id_ready <= 1'b0;
    repeat (12) @(posedge clk);
    id_ready <= 1'b1;
    @(posedge clk);
    id_ready <= 1'b0;
    repeat (2) @(posedge clk);
    clear_valid <= 1'b1;
    @(negedge clk);
    assert (instr_valid_id) else begin
      report_failure($sformatf("test %s: no word was held in IF/ID when the clear came",
                               test_name));
      $fatal(1);
    end
    @(posedge clk);
    clear_valid <= 1'b0;
    // valid stays low until decode takes again
    repeat (3) begin
      @(negedge clk);
      assert (!instr_valid_id) else begin
        report_failure($sformatf("FAILED %s valid after clear: expected 0, actual %b",
                                 test_name, instr_valid_id));
        $fatal(1);
      end
    end
    @(posedge clk);
    id_ready <= 1'b1;
    wait_accepted(4);

    @(posedge clk);
    $display("Verification passed");
    $finish;
  end

endmodule
